// ==== design/tcb_consts.svh ====
// bus widths, memory depth and manager count for the shared-memory subsystem
// include in any file that sizes a bus field or an array
`ifndef TCB_CONSTS_SVH
`define TCB_CONSTS_SVH

//////////////////////////////////////////////////
// bus fields
//////////////////////////////////////////////////

// word address, no byte offset bits
`define TCB_ADR_W 8

// data word
`define TCB_DAT_W 32

// one enable per data byte
`define TCB_BEN_W 4

//////////////////////////////////////////////////
// memory
//////////////////////////////////////////////////

// words actually present
// word addresses above this and up to 255 answer with err
`define TCB_MEM_WORDS 192

//////////////////////////////////////////////////
// interconnect
//////////////////////////////////////////////////

// peer managers at the top level
// also the default width of the arbiter and multiplexer
`define TCB_MGR_N 2

`endif

// ==== design/tcb_pkg.sv ====
// shared types of the bus: opcodes, request and response structs, memory states
// import inside module bodies, use scoped names in port lists
`include "tcb_consts.svh"

package tcb_pkg;

  //////////////////////////////////////////////////
  // opcode
  //////////////////////////////////////////////////

  // single bit, write when set
  typedef enum logic {
    OP_READ  = 1'b0,  // register word into response
    OP_WRITE = 1'b1   // store enabled bytes
  } tcb_op_e;

  //////////////////////////////////////////////////
  // request
  //////////////////////////////////////////////////

  // 45 bits in all
  // held stable by the manager while vld is high and rdy low
  typedef struct packed {
    tcb_op_e               op;   // read or write
    logic [`TCB_ADR_W-1:0] adr;  // word address
    logic [`TCB_BEN_W-1:0] ben;  // byte enables
    logic [`TCB_DAT_W-1:0] wdt;  // write data
  } tcb_req_t;

  //////////////////////////////////////////////////
  // response
  //////////////////////////////////////////////////

  // 33 bits
  // valid in the cycle after the transfer edge
  typedef struct packed {
    logic [`TCB_DAT_W-1:0] rdt;  // read data, zero for writes
    logic                  err;  // address beyond memory depth
  } tcb_rsp_t;

  //////////////////////////////////////////////////
  // memory access FSM
  //////////////////////////////////////////////////

  // idle accepts reads, full writes and errors directly
  // merge is the second cycle of a partial write
  typedef enum logic {
    MEM_IDLE  = 1'b0,
    MEM_MERGE = 1'b1
  } mem_state_e;

endpackage

// ==== design/tcb_arbiter.sv ====
// round-robin grant between managers sharing one bus
// sel is combinational from vld, priority moves past the winner on each transfer
module tcb_arbiter #(
  parameter  int unsigned SPN = 2,                          // manager count
  localparam int unsigned SPL = (SPN > 1) ? $clog2(SPN) : 1 // select width
)(
  input  logic           man,    // clock
  input  logic           rst_n,
  input  logic [SPN-1:0] vld,    // one request flag per manager
  input  logic           trn,    // transfer seen on the shared side
  output logic [SPL-1:0] sel     // granted manager
);

  //////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////

  logic [SPL-1:0] ptr;      // highest priority manager
  logic [SPL-1:0] ptr_nxt;  // one past the current winner
  logic [SPL-1:0] sel_q;    // last grant, reused when idle
  logic           hit;      // some manager is valid

  //////////////////////////////////////////////////
  // grant search
  //////////////////////////////////////////////////

  // circular scan from ptr, first valid manager wins
  always_comb begin
    int idx;
    idx = 0;
    hit = 1'b0;
    sel = sel_q;  // nobody asking, keep the old grant
    for (int i = 0; i < int'(SPN); i++) begin
      idx = (int'(ptr) + i) % int'(SPN);  // wrap past the last manager
      if (!hit && vld[idx]) begin
        hit = 1'b1;
        sel = SPL'(idx);
      end
    end
  end

  // manager after the winner, wrapping to 0
  assign ptr_nxt = (sel == SPL'(SPN - 1)) ? '0 : sel + 1'b1;

  //////////////////////////////////////////////////
  // priority state
  //////////////////////////////////////////////////

  // manager 0 first after reset
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      ptr <= '0;
    end else if (trn) begin
      ptr <= ptr_nxt;  // rotate only on completed transfers
    end
  end

  // remember grant so sel holds while nobody is valid
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      sel_q <= '0;
    end else if (hit) begin
      sel_q <= sel;
    end
  end

endmodule

// ==== design/tcb_multiplexer.sv ====
// steers the granted manager's request to the memory and routes the
// delayed response back to the manager that issued it
module tcb_multiplexer #(
  parameter  int unsigned SPN = 2,
  localparam int unsigned SPL = (SPN > 1) ? $clog2(SPN) : 1
)(
  input  logic              man,              // clock
  input  logic              rst_n,
  input  logic [SPL-1:0]    sel,              // grant from arbiter
  // manager side
  input  logic [SPN-1:0]    mgr_vld,
  input  tcb_pkg::tcb_req_t mgr_req [SPN-1:0],
  output logic [SPN-1:0]    mgr_rdy,
  output tcb_pkg::tcb_rsp_t mgr_rsp [SPN-1:0],
  // memory side
  output logic              mem_vld,
  output tcb_pkg::tcb_req_t mem_req,
  input  logic              mem_rdy,
  input  tcb_pkg::tcb_rsp_t mem_rsp,
  // handshake completion
  output logic              trn
);

  //////////////////////////////////////////////////
  // request path
  //////////////////////////////////////////////////

  // zero cycle pass through of the granted manager
  assign mem_vld = mgr_vld[sel];
  assign mem_req = mgr_req[sel];

  // transfer on the shared side, also rotates the arbiter
  assign trn = mem_vld & mem_rdy;

  //////////////////////////////////////////////////
  // response select
  //////////////////////////////////////////////////

  logic [SPL-1:0] rsp_sel;  // owner of the response in flight

  // captured at the transfer edge, so a new request from another
  // manager can be accepted while this response returns
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      rsp_sel <= '0;
    end else if (trn) begin
      rsp_sel <= sel;
    end
  end

  //////////////////////////////////////////////////
  // per manager fan-out
  //////////////////////////////////////////////////

  generate
    for (genvar i = 0; i < SPN; i++) begin : gen_mgr
      // waiting managers see rdy low
      assign mgr_rdy[i] = (sel == SPL'(i)) ? mem_rdy : 1'b0;
      // others read a zero response
      assign mgr_rsp[i] = (rsp_sel == SPL'(i)) ? mem_rsp : '0;
    end
  endgenerate

endmodule

// ==== design/tcb_memory.sv ====
// single-port word memory on the bus, one-cycle response
// partial writes take an extra read-merge cycle, out-of-range answers err
`include "tcb_consts.svh"

module tcb_memory (
  input  logic              man,    // clock
  input  logic              rst_n,
  input  logic              vld,
  input  tcb_pkg::tcb_req_t req,
  output logic              rdy,
  output tcb_pkg::tcb_rsp_t rsp
);
  import tcb_pkg::*;

  logic [`TCB_DAT_W-1:0] mem [0:`TCB_MEM_WORDS-1];  // storage array

  mem_state_e            state;    // access FSM
  logic                  in_rng;   // address inside the array
  logic                  wen;      // write opcode
  logic                  partial;  // in-range write, some bytes masked
  logic                  trn;      // transfer this edge
  logic [`TCB_DAT_W-1:0] old_q;    // word fetched for merge
  logic [`TCB_DAT_W-1:0] wr_word;  // merged store data

  //////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////

  assign in_rng  = int'(req.adr) < `TCB_MEM_WORDS;
  assign wen     = (req.op == OP_WRITE);
  assign partial = wen & in_rng & ~(&req.ben);

  // partial write waits one cycle in idle for the old word
  assign rdy = rst_n & ((state == MEM_MERGE) | ~partial);  // low in reset
  assign trn = vld & rdy;

  // enabled bytes from wdt, rest from the fetched word
  always_comb begin
    for (int b = 0; b < `TCB_BEN_W; b++) begin
      wr_word[8*b +: 8] = req.ben[b] ? req.wdt[8*b +: 8] : old_q[8*b +: 8];
    end
  end

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      state <= MEM_IDLE;
    end else begin
      case (state)
        MEM_IDLE:  if (vld && partial) state <= MEM_MERGE;  // fetch done
        MEM_MERGE: if (trn) state <= MEM_IDLE;              // stored
        default:   state <= MEM_IDLE;
      endcase
    end
  end

  // array and merge buffer
  always_ff @(posedge man) begin
    if (state == MEM_IDLE && vld && partial) old_q <= mem[req.adr];  // read for merge
    if (trn && wen && in_rng) mem[req.adr] <= wr_word;                // full or merged
  end

  // response, zero rdt on writes and errors
  always_ff @(posedge man or negedge rst_n) begin
    if (!rst_n) begin
      rsp <= '0;
    end else if (trn) begin
      rsp.err <= ~in_rng;
      rsp.rdt <= (in_rng && !wen) ? mem[req.adr] : '0;
    end
  end

endmodule

// ==== design/tcb_subsystem.sv ====
// top level of the shared-memory subsystem
// managers connect on the port arrays, one memory behind a round-robin mux
`include "tcb_consts.svh"

module tcb_subsystem (
  input  logic                  man,                      // clock
  input  logic                  rst_n,
  input  logic [`TCB_MGR_N-1:0] mgr_vld,                  // per manager request
  input  tcb_pkg::tcb_req_t     mgr_req [`TCB_MGR_N-1:0],
  output logic [`TCB_MGR_N-1:0] mgr_rdy,                  // per manager accept
  output tcb_pkg::tcb_rsp_t     mgr_rsp [`TCB_MGR_N-1:0]
);
  import tcb_pkg::*;

  localparam int unsigned SPL = (`TCB_MGR_N > 1) ? $clog2(`TCB_MGR_N) : 1;

  //////////////////////////////////////////////////
  // internal wires
  //////////////////////////////////////////////////

  logic [SPL-1:0] sel;      // grant
  logic           trn;      // shared side transfer
  logic           mem_vld;
  logic           mem_rdy;
  tcb_req_t       mem_req;  // selected request
  tcb_rsp_t       mem_rsp;  // registered memory answer

  //////////////////////////////////////////////////
  // instances
  //////////////////////////////////////////////////

  // picks the next manager
  tcb_arbiter #(
    .SPN (`TCB_MGR_N)
  ) u_arbiter (
    .man   (man),
    .rst_n (rst_n),
    .vld   (mgr_vld),
    .trn   (trn),
    .sel   (sel)
  );

  // request forward, response return
  tcb_multiplexer #(
    .SPN (`TCB_MGR_N)
  ) u_multiplexer (
    .man     (man),
    .rst_n   (rst_n),
    .sel     (sel),
    .mgr_vld (mgr_vld),
    .mgr_req (mgr_req),
    .mgr_rdy (mgr_rdy),
    .mgr_rsp (mgr_rsp),
    .mem_vld (mem_vld),
    .mem_req (mem_req),
    .mem_rdy (mem_rdy),
    .mem_rsp (mem_rsp),
    .trn     (trn)
  );

  // the only subordinate
  tcb_memory u_memory (
    .man   (man),
    .rst_n (rst_n),
    .vld   (mem_vld),
    .req   (mem_req),
    .rdy   (mem_rdy),
    .rsp   (mem_rsp)
  );

endmodule

// ==== verification/tcb_tb.sv ====
// table-driven testbench for the shared-memory subsystem
// a reference memory model and grant pointer predict every rdy and response
`include "tcb_consts.svh"

module tcb_tb;
  timeunit 1ns;
  timeprecision 100ps;

  import tcb_pkg::*;

  localparam int          N          = `TCB_MGR_N;
  localparam int          CLK_PERIOD = 8;   // ns
  localparam int          RST_CYCLES = 8;
  localparam int          N_ROWS     = 24;  // stimulus table length
  localparam int unsigned SEED       = 32'hdd52_9f81;
  localparam tcb_rsp_t    RSP_ZERO   = '0;  // what non-owners must read

  // one manager's part of a table row
  typedef struct packed {
    logic                  act;      // vld high in this row
    tcb_op_e               op;
    logic [`TCB_ADR_W-1:0] adr;
    logic [`TCB_BEN_W-1:0] ben;
    logic                  exp_err;  // expected err flag for this access
  } step_t;

  //////////////////////////////////////////////////
  // DUT and clock
  //////////////////////////////////////////////////

  logic         man;
  logic         rst_n;
  logic [N-1:0] mgr_vld;
  tcb_req_t     mgr_req [N-1:0];
  logic [N-1:0] mgr_rdy;
  tcb_rsp_t     mgr_rsp [N-1:0];

  tcb_subsystem uut (
    .man     (man),
    .rst_n   (rst_n),
    .mgr_vld (mgr_vld),
    .mgr_req (mgr_req),
    .mgr_rdy (mgr_rdy),
    .mgr_rsp (mgr_rsp)
  );

  always #(CLK_PERIOD / 2) man = ~man;  // 8 ns period

  //////////////////////////////////////////////////
  // table and reference model
  //////////////////////////////////////////////////

  step_t                 tbl [N_ROWS][N];
  logic [`TCB_DAT_W-1:0] mdl_mem [`TCB_MEM_WORDS];  // expected memory contents
  int                    exp_ptr;                   // expected arbiter priority
  mem_state_e            exp_state;                 // expected memory FSM state
  int                    rnd_adr [4];               // random in-range targets
  int                    rsp_errs;
  int                    grant_errs;
  int                    rdy_errs;

  // ends a stuck run, budget of 8 cycles per row
  initial begin
    #(N_ROWS * 8 * CLK_PERIOD);
    $display("ERROR: simulation hung, rows not done within %0d ns", N_ROWS * 8 * CLK_PERIOD);
    $display("Simulation failed");
    $finish;
  end

  //////////////////////////////////////////////////
  // compare tasks
  //////////////////////////////////////////////////

  task automatic check_rsp(input string name, input tcb_rsp_t exp, input tcb_rsp_t got);
    if (got !== exp) begin
      rsp_errs++;
      $display("FAILED %0t %s expected rdt=%h err=%b got rdt=%h err=%b",
               $realtime, name, exp.rdt, exp.err, got.rdt, got.err);
    end
  endtask

  task automatic check_grant(input int got, input int exp);
    if (got != exp) begin
      grant_errs++;  // -1 means no manager saw a transfer
      $display("FAILED %0t grant expected mgr %0d got mgr %0d", $realtime, exp, got);
    end
  endtask

  task automatic check_rdy(input string name, input logic exp, input logic got);
    if (got !== exp) begin
      rdy_errs++;
      $display("FAILED %0t %s expected %b got %b", $realtime, name, exp, got);
    end
  endtask

  //////////////////////////////////////////////////
  // prediction helpers
  //////////////////////////////////////////////////

  // first valid manager at or after ptr, wrapping
  function automatic int next_grant(input logic [N-1:0] v, input int ptr);
    int win;
    int idx;
    win = -1;
    for (int k = 0; k < N; k++) begin
      idx = (ptr + k) % N;
      if (win < 0 && v[idx]) win = idx;
    end
    return win;
  endfunction

  // applies one transfer to the model, returns the response it should give
  function automatic tcb_rsp_t model_access(input logic err, input tcb_req_t req);
    tcb_rsp_t rsp;
    rsp     = '0;
    rsp.err = err;
    if (!err) begin
      if (req.op == OP_WRITE) begin
        for (int b = 0; b < `TCB_BEN_W; b++) begin
          if (req.ben[b]) mdl_mem[req.adr][8*b +: 8] = req.wdt[8*b +: 8];  // enabled only
        end
      end else begin
        rsp.rdt = mdl_mem[req.adr];
      end
    end
    return rsp;  // writes and errors keep rdt zero
  endfunction

  //////////////////////////////////////////////////
  // stimulus table
  //////////////////////////////////////////////////

  task automatic set_step(input int r, input int m, input tcb_op_e op, input int adr,
                          input logic [`TCB_BEN_W-1:0] ben, input logic err);
    tbl[r][m].act     = 1'b1;
    tbl[r][m].op      = op;
    tbl[r][m].adr     = `TCB_ADR_W'(adr);
    tbl[r][m].ben     = ben;
    tbl[r][m].exp_err = err;
  endtask

  task automatic build_table();
    for (int r = 0; r < N_ROWS; r++) begin
      for (int m = 0; m < N; m++) tbl[r][m] = '0;
    end
    for (int i = 0; i < 4; i++) rnd_adr[i] = int'($urandom_range(`TCB_MEM_WORDS - 1, 0));
    // contention right after reset, mgr 0 goes first
    set_step(0, 0, OP_WRITE, 10, 4'hf, 1'b0);
    set_step(0, 1, OP_WRITE, 20, 4'hf, 1'b0);
    set_step(1, 0, OP_READ, 20, 4'h0, 1'b0);     // each answer to its owner
    set_step(1, 1, OP_READ, 10, 4'h0, 1'b0);
    set_step(2, 0, OP_WRITE, 10, 4'b0011, 1'b0); // merge while mgr 1 waits
    set_step(2, 1, OP_WRITE, 30, 4'hf, 1'b0);
    set_step(3, 0, OP_READ, 30, 4'h0, 1'b0);
    set_step(3, 1, OP_READ, 10, 4'h0, 1'b0);
    // single manager, full writes then read back
    for (int i = 0; i < 4; i++) begin
      set_step(4 + i, 0, OP_WRITE, rnd_adr[i], 4'hf, 1'b0);
      set_step(8 + i, 0, OP_READ, rnd_adr[i], 4'h0, 1'b0);
    end
    // partial writes, one wait cycle each
    set_step(12, 1, OP_WRITE, rnd_adr[0], 4'b0101, 1'b0);
    set_step(13, 1, OP_READ, rnd_adr[0], 4'h0, 1'b0);
    set_step(14, 0, OP_WRITE, 20, 4'b1000, 1'b0);
    set_step(15, 0, OP_READ, 20, 4'h0, 1'b0);
    // out of range, nothing stored
    set_step(16, 0, OP_READ, 200, 4'h0, 1'b1);
    set_step(17, 1, OP_WRITE, 255, 4'hf, 1'b1);
    set_step(18, 1, OP_WRITE, 192, 4'b0001, 1'b1);  // partial but no merge cycle
    set_step(19, 0, OP_READ, rnd_adr[1], 4'h0, 1'b0);
    set_step(20, 1, OP_READ, 30, 4'h0, 1'b0);
    // mixed contention
    set_step(21, 0, OP_READ, 255, 4'h0, 1'b1);
    set_step(21, 1, OP_READ, rnd_adr[2], 4'h0, 1'b0);
    set_step(22, 0, OP_WRITE, rnd_adr[3], 4'hf, 1'b0);
    set_step(22, 1, OP_WRITE, 30, 4'b0110, 1'b0);
    set_step(23, 0, OP_READ, 30, 4'h0, 1'b0);
    set_step(23, 1, OP_READ, rnd_adr[3], 4'h0, 1'b0);
  endtask

  //////////////////////////////////////////////////
  // row runner
  //////////////////////////////////////////////////

  // entered on a falling edge, holds the row until every valid manager is done
  task automatic run_row(input int r);
    logic [N-1:0] pend;     // managers still waiting
    int           g;        // predicted grant
    int           seen;     // manager that saw a transfer
    logic         part;     // partial in-range write
    logic         xfer;     // transfer expected at this edge
    tcb_req_t     req;
    tcb_rsp_t     rsp_exp;
    pend    = '0;
    rsp_exp = '0;
    for (int m = 0; m < N; m++) begin
      if (tbl[r][m].act) begin
        pend[m]        = 1'b1;
        mgr_req[m].op  = tbl[r][m].op;
        mgr_req[m].adr = tbl[r][m].adr;
        mgr_req[m].ben = tbl[r][m].ben;
        mgr_req[m].wdt = (tbl[r][m].op == OP_WRITE) ? $urandom() : '0;
      end
    end
    mgr_vld = pend;
    while (pend != '0) begin
      #(CLK_PERIOD / 2 - 1);  // just ahead of the rising edge, all settled
      g    = next_grant(mgr_vld, exp_ptr);
      req  = mgr_req[g];
      part = (req.op == OP_WRITE) && !tbl[r][g].exp_err && (req.ben != '1);
      xfer = !(part && exp_state == MEM_IDLE);  // first cycle of a merge waits
      seen = -1;
      for (int m = 0; m < N; m++) begin
        check_rdy($sformatf("mgr_rdy[%0d] in %s", m, exp_state.name()),
                  (m == g) && xfer, mgr_rdy[m]);
        if (mgr_vld[m] && mgr_rdy[m]) seen = m;
      end
      if (xfer) begin
        check_grant(seen, g);
        rsp_exp   = model_access(tbl[r][g].exp_err, req);
        exp_ptr   = (g + 1) % N;  // rotate past the winner
        exp_state = MEM_IDLE;
      end else begin
        exp_state = MEM_MERGE;
      end
      @(posedge man);
      @(negedge man);
      if (xfer) begin
        // response lives in this cycle only
        for (int m = 0; m < N; m++) begin
          check_rsp($sformatf("mgr_rsp[%0d]", m), (m == g) ? rsp_exp : RSP_ZERO, mgr_rsp[m]);
        end
        pend[g]    = 1'b0;
        mgr_vld[g] = 1'b0;
      end
    end
  endtask

  //////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////

  initial begin
    $timeformat(-9, 1, " ns", 0);
    void'($urandom(SEED));  // seeds the generator once
    man        = 1'b0;
    rst_n      = 1'b0;
    mgr_vld    = '0;
    for (int m = 0; m < N; m++) mgr_req[m] = '0;
    exp_ptr    = 0;
    exp_state  = MEM_IDLE;
    rsp_errs   = 0;
    grant_errs = 0;
    rdy_errs   = 0;
    build_table();

    // reset, nothing accepted and responses zero
    repeat (RST_CYCLES) begin
      @(negedge man);
      for (int m = 0; m < N; m++) begin
        check_rdy($sformatf("mgr_rdy[%0d] in reset", m), 1'b0, mgr_rdy[m]);
        check_rsp($sformatf("mgr_rsp[%0d] in reset", m), RSP_ZERO, mgr_rsp[m]);
      end
    end
    rst_n = 1'b1;

    for (int r = 0; r < N_ROWS; r++) run_row(r);

    $display("errors: rsp %0d, grant %0d, rdy %0d", rsp_errs, grant_errs, rdy_errs);
    if (rsp_errs + grant_errs + rdy_errs == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+design
design/tcb_pkg.sv
design/tcb_arbiter.sv
design/tcb_multiplexer.sv
design/tcb_memory.sv
design/tcb_subsystem.sv
verification/tcb_tb.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the testbench with Verilator, pass only if the log says so

cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=tcb_tb_sim

rm -rf obj_dir
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/100ps \
  -f project.f --top-module tcb_tb -Mdir obj_dir -o "$BIN"
status=$?
if [ "$status" -ne 0 ]; then
  echo "build failed with status $status"
  exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
